/* src/switch_cfg_pkg.sv */
package switch_cfg_pkg;

    // switch geometry.
    localparam int num_ports   = 8;
    localparam int prio_levels = 8;

    // derived widths.
    localparam int port_id_w = $clog2(num_ports);
    localparam int prio_w    = $clog2(prio_levels);

    // index of one input port.
    typedef logic [port_id_w-1:0] port_id_t;

    // one priority value, larger is more urgent.
    typedef logic [prio_w-1:0] prio_t;

    // one bit per input port.
    typedef logic [num_ports-1:0] port_vec_t;

    // all priorities packed, input 0 in the low bits.
    typedef logic [num_ports*prio_w-1:0] prio_vec_t;

endpackage

/* src/flow_pkg.sv */
package flow_pkg;

    // slots in the downstream output buffer.
    localparam int max_credits = 4;

    // wide enough to hold max_credits itself.
    localparam int credit_w = $clog2(max_credits + 1);

    // count of free downstream slots.
    typedef logic [credit_w-1:0] credit_t;

endpackage

/* src/compare_unit.sv */
`timescale 1ns/1ps

module compare_unit (
    input  logic                   a_valid,
    input  switch_cfg_pkg::prio_t    a_prio,
    input  switch_cfg_pkg::port_id_t a_port,
    input  logic                   b_valid,
    input  switch_cfg_pkg::prio_t    b_prio,
    input  switch_cfg_pkg::port_id_t b_port,
    output logic                   out_valid,
    output switch_cfg_pkg::prio_t    out_prio,
    output switch_cfg_pkg::port_id_t out_port
);

    import switch_cfg_pkg::*;

    // side a carries the lower indices, so it wins ties.
    logic a_wins;

    assign a_wins = (a_prio >= b_prio);

    always_comb begin
        case ({a_valid, b_valid})
            2'b10: begin
                out_valid = 1'b1;
                out_prio  = a_prio;
                out_port  = a_port;
            end
            2'b01: begin
                out_valid = 1'b1;
                out_prio  = b_prio;
                out_port  = b_port;
            end
            2'b11: begin
                out_valid = 1'b1;
                out_prio  = a_wins ? a_prio : b_prio;
                out_port  = a_wins ? a_port : b_port;
            end
            default: begin
                out_valid = 1'b0;
                out_prio  = prio_t'(0);
                out_port  = port_id_t'(0);
            end
        endcase
    end

endmodule

/* src/compare_tree.sv */
`timescale 1ns/1ps

module compare_tree (
    input  switch_cfg_pkg::port_vec_t valid_in,
    input  switch_cfg_pkg::prio_vec_t prio_in,
    output logic                    best_valid,
    output switch_cfg_pkg::prio_t     best_prio,
    output switch_cfg_pkg::port_id_t  best_port
);

    import switch_cfg_pkg::*;

    logic [num_ports*port_id_w-1:0] port_in;

    // each leaf carries its own index up the tree.
    for (genvar i = 0; i < num_ports; i++) begin : g_port_id
        assign port_in[i*port_id_w +: port_id_w] = port_id_t'(i);
    end

    compare_tree_internal #(
        .port_count(num_ports)
    ) tree0 (
        .valid_in (valid_in),
        .port_in  (port_in),
        .prio_in  (prio_in),
        .out_valid(best_valid),
        .out_prio (best_prio),
        .out_port (best_port)
    );

endmodule

module compare_tree_internal #(
    parameter int port_count = 8
) (
    input  logic [port_count-1:0]                           valid_in,
    input  logic [port_count*switch_cfg_pkg::port_id_w-1:0] port_in,
    input  logic [port_count*switch_cfg_pkg::prio_w-1:0]    prio_in,
    output logic                                            out_valid,
    output switch_cfg_pkg::prio_t                             out_prio,
    output switch_cfg_pkg::port_id_t                          out_port
);

    import switch_cfg_pkg::*;

    localparam int half = port_count / 2;

    // lower half goes to side a.
    logic [half-1:0]           a_valid, b_valid;
    logic [half*port_id_w-1:0] a_port, b_port;
    logic [half*prio_w-1:0]    a_prio, b_prio;

    assign {b_valid, a_valid} = valid_in;
    assign {b_port, a_port}   = port_in;
    assign {b_prio, a_prio}   = prio_in;

    if (port_count == 2) begin : g_leaf
        compare_unit unit0 (
            .a_valid  (a_valid),
            .a_prio   (a_prio),
            .a_port   (a_port),
            .b_valid  (b_valid),
            .b_prio   (b_prio),
            .b_port   (b_port),
            .out_valid(out_valid),
            .out_prio (out_prio),
            .out_port (out_port)
        );
    end else begin : g_node
        logic     a_best_valid, b_best_valid;
        prio_t    a_best_prio, b_best_prio;
        port_id_t a_best_port, b_best_port;

        compare_tree_internal #(
            .port_count(half)
        ) sub_a (
            .valid_in (a_valid),
            .port_in  (a_port),
            .prio_in  (a_prio),
            .out_valid(a_best_valid),
            .out_prio (a_best_prio),
            .out_port (a_best_port)
        );

        compare_tree_internal #(
            .port_count(half)
        ) sub_b (
            .valid_in (b_valid),
            .port_in  (b_port),
            .prio_in  (b_prio),
            .out_valid(b_best_valid),
            .out_prio (b_best_prio),
            .out_port (b_best_port)
        );

        compare_unit unit_ab (
            .a_valid  (a_best_valid),
            .a_prio   (a_best_prio),
            .a_port   (a_best_port),
            .b_valid  (b_best_valid),
            .b_prio   (b_best_prio),
            .b_port   (b_best_port),
            .out_valid(out_valid),
            .out_prio (out_prio),
            .out_port (out_port)
        );
    end

endmodule

/* src/request_table.sv */
`timescale 1ns/1ps

module request_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  switch_cfg_pkg::port_vec_t req_valid,
    input  switch_cfg_pkg::prio_vec_t req_prio,
    input  logic                    grant_fire,
    input  switch_cfg_pkg::port_id_t  grant_port,
    output switch_cfg_pkg::port_vec_t pending,
    output switch_cfg_pkg::prio_vec_t stored_prio
);

    import switch_cfg_pkg::*;

    port_vec_t pending_q;
    prio_vec_t prio_q;
    port_vec_t set_mask;
    port_vec_t clr_mask;

    // requests on busy entries are dropped.
    assign set_mask = req_valid & ~pending_q;

    assign clr_mask = grant_fire ? (port_vec_t'(1) << grant_port) : port_vec_t'(0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask) | set_mask;
        end
    end

    // priority is captured only when the entry is taken.
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_ports; i++) begin
            if (set_mask[i]) begin
                prio_q[i*prio_w +: prio_w] <= req_prio[i*prio_w +: prio_w];
            end
        end
    end

    assign pending     = pending_q;
    assign stored_prio = prio_q;

    // a grant always targets a live entry.
    a_grant_hits_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_fire |-> ((pending_q & clr_mask) != '0)
    );

endmodule

/* src/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              consume,
    input  logic              credit_return,
    output logic              credit_avail,
    output flow_pkg::credit_t credits
);

    import flow_pkg::*;

    credit_t count_q;

    // simultaneous use and return cancel out.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= credit_t'(max_credits);
        end else begin
            case ({consume, credit_return})
                2'b10: count_q <= count_q - credit_t'(1);
                2'b01: count_q <= count_q + credit_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign credit_avail = (count_q != '0);
    assign credits      = count_q;

    // downstream never returns more than it was given.
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_q <= credit_t'(max_credits)
    );

    // grant logic upstream must respect an empty buffer.
    a_no_grant_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        consume |-> (count_q != '0)
    );

endmodule

/* src/output_scheduler.sv */
`timescale 1ns/1ps

module output_scheduler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  switch_cfg_pkg::port_vec_t req_valid,
    input  switch_cfg_pkg::prio_vec_t req_prio,
    output switch_cfg_pkg::port_vec_t pending,
    input  logic                    credit_return,
    output logic                    grant_valid,
    output switch_cfg_pkg::port_id_t  grant_port,
    output switch_cfg_pkg::prio_t     grant_prio,
    output flow_pkg::credit_t         credits
);

    import switch_cfg_pkg::*;

    prio_vec_t stored_prio;
    logic      best_valid;
    prio_t     best_prio;
    port_id_t  best_port;
    logic      credit_avail;
    logic      grant_fire;

    request_table table0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_prio   (req_prio),
        .grant_fire (grant_fire),
        .grant_port (best_port),
        .pending    (pending),
        .stored_prio(stored_prio)
    );

    compare_tree tree0 (
        .valid_in  (pending),
        .prio_in   (stored_prio),
        .best_valid(best_valid),
        .best_prio (best_prio),
        .best_port (best_port)
    );

    credit_counter credit0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .consume      (grant_fire),
        .credit_return(credit_return),
        .credit_avail (credit_avail),
        .credits      (credits)
    );

    // one grant per cycle, only with a free slot downstream.
    assign grant_fire = best_valid & credit_avail;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= grant_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_fire) begin
            grant_port <= best_port;
            grant_prio <= best_prio;
        end
    end

    // the granted input was pending on the previous cycle.
    a_grant_port_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_valid |-> ((($past(pending) >> grant_port) & port_vec_t'(1)) != '0)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real period = 4.0
) (
    output logic clk
);

    // free running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0);
            clk = ~clk;
        end
    end

endmodule

/* test/output_scheduler_tb.sv */
`timescale 1ns/1ps

module output_scheduler_tb;

    import switch_cfg_pkg::*;
    import flow_pkg::*;

    localparam real clk_period = 4.0;
    localparam int  n_random   = 200;

    logic      clk;
    logic      rst_n;
    port_vec_t req_valid;
    prio_vec_t req_prio;
    port_vec_t pending;
    logic      credit_return;
    logic      grant_valid;
    port_id_t  grant_port;
    prio_t     grant_prio;
    credit_t   credits;

    // directed steps with the grant each one should show.
    port_vec_t tbl_valid[$];
    prio_vec_t tbl_prio[$];
    logic      tbl_ret[$];
    logic      tbl_gv[$];
    port_id_t  tbl_gport[$];
    prio_t     tbl_gprio[$];

    // reference model state.
    port_vec_t m_pending;
    prio_t     m_prio[num_ports];
    int        m_credits;
    logic      m_gv;
    port_id_t  m_gport;
    prio_t     m_gprio;

    int checks;
    int errors;

    tb_clock #(.period(clk_period)) clk0 (.clk(clk));

    output_scheduler dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_prio     (req_prio),
        .pending      (pending),
        .credit_return(credit_return),
        .grant_valid  (grant_valid),
        .grant_port   (grant_port),
        .grant_prio   (grant_prio),
        .credits      (credits)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic add_step(input port_vec_t valid, input prio_vec_t prio, input logic ret,
                            input logic gv, input port_id_t gport, input prio_t gprio);
        tbl_valid.push_back(valid);
        tbl_prio.push_back(prio);
        tbl_ret.push_back(ret);
        tbl_gv.push_back(gv);
        tbl_gport.push_back(gport);
        tbl_gprio.push_back(gprio);
    endtask

    // priorities in octal with one digit per port and port 7 on the left.
    task automatic build_table();
        add_step(8'h00, 24'o00000000, 1'b0, 1'b0, 3'd0, 3'd0);
        // single request on port 2.
        add_step(8'h04, 24'o00000500, 1'b0, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b1, 3'd2, 3'd5);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b0, 3'd0, 3'd0);
        // ports 1, 3, 5 and 6 at once with 3 and 5 tied.
        add_step(8'h6a, 24'o02606030, 1'b0, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b1, 3'd3, 3'd6);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b1, 3'd5, 3'd6);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b1, 3'd1, 3'd3);
        // out of credits while port 6 asks again and port 4 joins.
        add_step(8'h50, 24'o07010000, 1'b0, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b1, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b1, 3'd6, 3'd2);
        // port 4 waits for the next return.
        add_step(8'h00, 24'o00000000, 1'b1, 1'b0, 3'd0, 3'd0);
        // return lands with the grant so the count holds at 1.
        add_step(8'h00, 24'o00000000, 1'b1, 1'b1, 3'd4, 3'd1);
        add_step(8'h00, 24'o00000000, 1'b0, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b1, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b1, 1'b0, 3'd0, 3'd0);
        add_step(8'h00, 24'o00000000, 1'b1, 1'b0, 3'd0, 3'd0);
    endtask

    task automatic model_step(input port_vec_t valid, input prio_vec_t prio, input logic ret);
        int        best;
        logic      fire;
        port_vec_t taken;
        best = -1;
        for (int i = 0; i < num_ports; i++) begin
            // strict compare keeps ties on the lower index.
            if (m_pending[i] && (best < 0 || m_prio[i] > m_prio[best])) begin
                best = i;
            end
        end
        fire  = (best >= 0) && (m_credits > 0);
        taken = valid & ~m_pending;
        m_gv  = fire;
        if (fire) begin
            m_gport         = port_id_t'(best);
            m_gprio         = m_prio[best];
            m_pending[best] = 1'b0;
            m_credits--;
        end
        if (ret) begin
            m_credits++;
        end
        m_pending = m_pending | taken;
        for (int i = 0; i < num_ports; i++) begin
            if (taken[i]) begin
                m_prio[i] = prio[i*prio_w +: prio_w];
            end
        end
    endtask

    task automatic compare_outputs();
        check_value("pending", 32'(m_pending), 32'(pending));
        check_value("credits", m_credits, 32'(credits));
        check_value("grant_valid", 32'(m_gv), 32'(grant_valid));
        if (m_gv) begin
            check_value("grant_port", 32'(m_gport), 32'(grant_port));
            check_value("grant_prio", 32'(m_gprio), 32'(grant_prio));
        end
    endtask

    task automatic apply_step(input port_vec_t valid, input prio_vec_t prio, input logic ret);
        req_valid     = valid;
        req_prio      = prio;
        credit_return = ret;
        model_step(valid, prio, ret);
        @(posedge clk);
        #1;
        compare_outputs();
    endtask

    initial begin
        logic [31:0] rng;
        port_vec_t   rnd_valid;
        prio_vec_t   rnd_prio;
        logic        rnd_ret;

        rst_n         = 1'b0;
        req_valid     = '0;
        req_prio      = '0;
        credit_return = 1'b0;
        checks        = 0;
        errors        = 0;
        m_pending     = '0;
        m_credits     = max_credits;
        m_gv          = 1'b0;
        m_gport       = '0;
        m_gprio       = '0;
        for (int i = 0; i < num_ports; i++) begin
            m_prio[i] = '0;
        end
        build_table();

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // state straight out of reset.
        compare_outputs();

        for (int s = 0; s < tbl_valid.size(); s++) begin
            apply_step(tbl_valid[s], tbl_prio[s], tbl_ret[s]);
            check_value("grant_valid (table)", 32'(tbl_gv[s]), 32'(grant_valid));
            if (tbl_gv[s]) begin
                check_value("grant_port (table)", 32'(tbl_gport[s]), 32'(grant_port));
                check_value("grant_prio (table)", 32'(tbl_gprio[s]), 32'(grant_prio));
            end
        end

        rng = 32'hbf81_a458;
        for (int n = 0; n < n_random; n++) begin
            rng       = lcg_next(rng);
            rnd_valid = rng[31:24] & rng[23:16];
            rng       = lcg_next(rng);
            rnd_prio  = rng[31:8];
            rng       = lcg_next(rng);
            // downstream only returns slots it actually holds.
            rnd_ret   = (rng[31:30] != 2'b00) && (m_credits < max_credits);
            apply_step(rnd_valid, rnd_prio, rnd_ret);
        end

        req_valid     = '0;
        credit_return = 1'b0;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        real limit;
        #1;
        limit = (tbl_valid.size() + n_random + 20) * clk_period;
        #(limit);
        $display("timeout: run did not finish within %0.1f ns", limit);
        $display("Test failed");
        $finish;
    end

endmodule

/* output_scheduler.f */
src/switch_cfg_pkg.sv
src/flow_pkg.sv
src/compare_unit.sv
src/compare_tree.sv
src/request_table.sv
src/credit_counter.sv
src/output_scheduler.sv
test/tb_clock.sv
test/output_scheduler_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the output scheduler testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f output_scheduler.f \
    --top-module output_scheduler_tb \
    -Mdir "$build_dir" -o sim_output_scheduler
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_output_scheduler" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log_file"; then
    exit 1
fi
exit 0
